//--- Makefile
VERILATOR  ?= verilator
TOP        ?= tb_dispatch
DUT_TOP    ?= dispatch_top
FILELIST   ?= list.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only -Wall

SRCS     := $(shell grep -v '^+' $(FILELIST))
RTL_SRCS := $(filter hdl/%,$(SRCS))

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(DUT_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR)

//--- hdl/dispatch.sv
// dispatch: renames the instruction FIFO head and pushes it to its issue queue and the ROB
module dispatch (
	input  dispatch_pkg::decode_info_t                               head,
	input  logic                                                     instr_empty,
	output logic                                                     instr_pop,
	input  logic                                                     rob_full,
	output logic                                                     rob_push,
	output dispatch_pkg::rob_info_t                                  rob_info,
	input  logic [dispatch_pkg::UNITS-1:0]                           iss_full,
	output logic [dispatch_pkg::UNITS-1:0]                           iss_push,
	output dispatch_pkg::issue_info_t                                iss_info,
	input  logic [dispatch_pkg::ARCH_REGS-1:0][dispatch_pkg::RB-1:0] act,
	input  logic [dispatch_pkg::ARCH_REGS-1:0][dispatch_pkg::RP-1:0] used,
	output logic                                                     alloc,
	output dispatch_pkg::reg_tag_t                                   alloc_tag
);
	dispatch_pkg::unit_e           unit;
	dispatch_pkg::reg_tag_t        rs1_tag;
	dispatch_pkg::reg_tag_t        rs2_tag;
	dispatch_pkg::reg_tag_t        rd_tag;
	dispatch_pkg::reg_tag_t        rd_prev_tag;
	logic                          rd_runout;
	logic [dispatch_pkg::UNITS-1:0] unit_sel;   // one-hot target queue
	logic                          unit_busy;
	logic                          fire;
	logic                          rd_valid;

	rename u_rename (
		.act         (act),
		.used        (used),
		.rs1         (head.rs1),
		.rs2         (head.rs2),
		.rd          (head.rd),
		.rs1_tag     (rs1_tag),
		.rs2_tag     (rs2_tag),
		.rd_tag      (rd_tag),
		.rd_prev_tag (rd_prev_tag),
		.rd_runout   (rd_runout)
	);

	// --------------------------------------------------
	// dispatch decision
	// --------------------------------------------------
	assign unit = dispatch_pkg::unit_of(head.op);

	always_comb begin
		for (int u = 0; u < dispatch_pkg::UNITS; u++)
			unit_sel[u] = (unit == dispatch_pkg::unit_e'(u));  // unit_none selects nothing
	end

	assign unit_busy = |(unit_sel & iss_full);
	assign fire      = !instr_empty && !rob_full && !rd_runout && !unit_busy;
	assign rd_valid  = (head.rd != 5'd0);

	assign instr_pop = fire;
	assign rob_push  = fire;
	assign iss_push  = unit_sel & {dispatch_pkg::UNITS{fire}};
	assign alloc     = fire && rd_valid;
	assign alloc_tag = rd_tag;

	// --------------------------------------------------
	// records
	// --------------------------------------------------
	assign iss_info = '{op: head.op, pc: head.pc, imm: head.imm,
		rd: rd_tag, rs1: rs1_tag, rs2: rs2_tag};

	always_comb begin
		rob_info           = '0;
		rob_info.pc        = head.pc;
		rob_info.rd        = rd_tag;
		rob_info.rd_prev   = rd_prev_tag;
		rob_info.rd_valid  = rd_valid;
		rob_info.is_branch = head.op inside {dispatch_pkg::op_beq, dispatch_pkg::op_bne};
		rob_info.is_ls     = head.op inside {dispatch_pkg::op_ld, dispatch_pkg::op_sd};
		rob_info.is_csr    = head.op inside {dispatch_pkg::op_csrrw, dispatch_pkg::op_csrrs};
		rob_info.is_priv   = (unit == dispatch_pkg::unit_none);
	end

	// copies read or replaced by a dispatched instruction are still live
	always_comb begin
		a_live_copies: assert final (!rob_push
			|| (used[rs1_tag.idx][rs1_tag.copy] && used[rs2_tag.idx][rs2_tag.copy]
			&& used[rd_prev_tag.idx][rd_prev_tag.copy]))
			else $error("dispatch reads a released register copy");
	end

endmodule

//--- hdl/dispatch_pkg.sv
// dispatch package: queue sizes, opcode and unit encodings, queue payload structs
package dispatch_pkg;

	// --------------------------------------------------
	// sizes
	// --------------------------------------------------
	localparam int ARCH_REGS   = 32;  // architectural registers
	localparam int RP          = 4;   // copies per register
	localparam int RB          = 2;   // copy index width
	localparam int INSTR_DEPTH = 4;
	localparam int ISSUE_DEPTH = 4;
	localparam int ROB_DEPTH   = 8;
	localparam int UNITS       = 5;   // issue queues

	// --------------------------------------------------
	// encodings
	// --------------------------------------------------
	typedef enum logic [4:0] {
		op_add, op_sub, op_and, op_or, op_xor, op_slt, op_lui, op_addi,  // alu
		op_jal, op_beq, op_bne,                                          // bru
		op_ld, op_sd, op_fence,                                          // lsu
		op_csrrw, op_csrrs,                                              // csr
		op_mul, op_div,                                                  // mul
		op_ecall, op_ebreak, op_mret                                     // privileged
	} op_e;

	// first five values index the issue queues
	typedef enum logic [2:0] {
		unit_alu,
		unit_bru,
		unit_lsu,
		unit_csr,
		unit_mul,
		unit_none  // privileged, reorder entry only
	} unit_e;

	// --------------------------------------------------
	// payloads
	// --------------------------------------------------
	typedef struct packed {
		logic [4:0]    idx;   // architectural register
		logic [RB-1:0] copy;  // which copy of it
	} reg_tag_t;

	typedef struct packed {
		op_e         op;
		logic [63:0] pc;
		logic [63:0] imm;
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
	} decode_info_t;

	typedef struct packed {
		op_e         op;
		logic [63:0] pc;
		logic [63:0] imm;
		reg_tag_t    rd;
		reg_tag_t    rs1;
		reg_tag_t    rs2;
	} issue_info_t;

	typedef struct packed {
		logic [63:0] pc;
		reg_tag_t    rd;
		reg_tag_t    rd_prev;    // copy freed at commit
		logic        rd_valid;
		logic        is_branch;
		logic        is_ls;
		logic        is_csr;
		logic        is_priv;
	} rob_info_t;

	// which issue queue takes an opcode
	function automatic unit_e unit_of(op_e op);
		case (op)
			op_add, op_sub, op_and, op_or, op_xor, op_slt, op_lui, op_addi: return unit_alu;
			op_jal, op_beq, op_bne:                                         return unit_bru;
			op_ld, op_sd, op_fence:                                         return unit_lsu;
			op_csrrw, op_csrrs:                                             return unit_csr;
			op_mul, op_div:                                                 return unit_mul;
			default:                                                        return unit_none;
		endcase
	endfunction

endpackage

//--- hdl/dispatch_top.sv
// dispatch subsystem: instruction FIFO, dispatch, rename tables, issue FIFOs and reorder FIFO
module dispatch_top (
	input  logic                             CLK,
	input  logic                             rst_n,
	input  logic                             instr_push,
	input  dispatch_pkg::decode_info_t       instr_info,
	output logic                             instr_full,
	input  logic [dispatch_pkg::UNITS-1:0]   iss_pop,
	output dispatch_pkg::issue_info_t        iss_data [dispatch_pkg::UNITS],
	output logic [dispatch_pkg::UNITS-1:0]   iss_empty,
	input  logic                             rob_pop,
	output dispatch_pkg::rob_info_t          rob_data,
	output logic                             rob_empty
);
	dispatch_pkg::decode_info_t                               instr_head;
	logic                                                     instr_empty;
	logic                                                     instr_pop;
	logic [dispatch_pkg::UNITS-1:0]                           iss_push;
	logic [dispatch_pkg::UNITS-1:0]                           iss_full;
	dispatch_pkg::issue_info_t                                iss_info;
	logic                                                     rob_push;
	logic                                                     rob_full;
	dispatch_pkg::rob_info_t                                  rob_info;
	logic [dispatch_pkg::ARCH_REGS-1:0][dispatch_pkg::RB-1:0] act;
	logic [dispatch_pkg::ARCH_REGS-1:0][dispatch_pkg::RP-1:0] used;
	logic                                                     alloc;
	dispatch_pkg::reg_tag_t                                   alloc_tag;
	logic                                                     release_valid;

	// --------------------------------------------------
	// front
	// --------------------------------------------------
	sync_fifo #(.DEPTH(dispatch_pkg::INSTR_DEPTH), .T(dispatch_pkg::decode_info_t)) u_instr_fifo (
		.CLK   (CLK),
		.rst_n (rst_n),
		.push  (instr_push),
		.in    (instr_info),
		.pop   (instr_pop),
		.out   (instr_head),
		.full  (instr_full),
		.empty (instr_empty)
	);

	dispatch u_dispatch (
		.head        (instr_head),
		.instr_empty (instr_empty),
		.instr_pop   (instr_pop),
		.rob_full    (rob_full),
		.rob_push    (rob_push),
		.rob_info    (rob_info),
		.iss_full    (iss_full),
		.iss_push    (iss_push),
		.iss_info    (iss_info),
		.act         (act),
		.used        (used),
		.alloc       (alloc),
		.alloc_tag   (alloc_tag)
	);

	// commit of a writer frees the copy it replaced
	assign release_valid = rob_pop && !rob_empty && rob_data.rd_valid;

	rename_state u_rename_state (
		.CLK           (CLK),
		.rst_n         (rst_n),
		.alloc         (alloc),
		.alloc_tag     (alloc_tag),
		.release_valid (release_valid),
		.release_tag   (rob_data.rd_prev),
		.act           (act),
		.used          (used)
	);

	// --------------------------------------------------
	// back
	// --------------------------------------------------
	for (genvar u = 0; u < dispatch_pkg::UNITS; u++) begin : g_issue
		sync_fifo #(.DEPTH(dispatch_pkg::ISSUE_DEPTH), .T(dispatch_pkg::issue_info_t)) u_iss (
			.CLK   (CLK),
			.rst_n (rst_n),
			.push  (iss_push[u]),
			.in    (iss_info),  // shared, only one queue pushes
			.pop   (iss_pop[u]),
			.out   (iss_data[u]),
			.full  (iss_full[u]),
			.empty (iss_empty[u])
		);
	end

	sync_fifo #(.DEPTH(dispatch_pkg::ROB_DEPTH), .T(dispatch_pkg::rob_info_t)) u_rob_fifo (
		.CLK   (CLK),
		.rst_n (rst_n),
		.push  (rob_push),
		.in    (rob_info),
		.pop   (rob_pop),
		.out   (rob_data),
		.full  (rob_full),
		.empty (rob_empty)
	);

endmodule

//--- hdl/rename.sv
// register rename lookup: source tags from the active table, free copy search for rd
module rename (
	input  logic [dispatch_pkg::ARCH_REGS-1:0][dispatch_pkg::RB-1:0] act,
	input  logic [dispatch_pkg::ARCH_REGS-1:0][dispatch_pkg::RP-1:0] used,
	input  logic [4:0]                                               rs1,
	input  logic [4:0]                                               rs2,
	input  logic [4:0]                                               rd,
	output dispatch_pkg::reg_tag_t                                   rs1_tag,
	output dispatch_pkg::reg_tag_t                                   rs2_tag,
	output dispatch_pkg::reg_tag_t                                   rd_tag,
	output dispatch_pkg::reg_tag_t                                   rd_prev_tag,
	output logic                                                     rd_runout
);
	logic [dispatch_pkg::RP-1:0] rd_used;    // copies of rd in flight
	logic [dispatch_pkg::RB-1:0] free_copy;
	logic                        free_found;
	logic                        rd_is_x0;

	assign rd_used  = used[rd];
	assign rd_is_x0 = (rd == 5'd0);

	// --------------------------------------------------
	// sources read the copy that is active now
	// --------------------------------------------------
	assign rs1_tag = '{idx: rs1, copy: act[rs1]};
	assign rs2_tag = '{idx: rs2, copy: act[rs2]};

	// --------------------------------------------------
	// destination
	// --------------------------------------------------
	// scan down so the lowest free copy wins
	always_comb begin
		free_copy  = '0;
		free_found = 1'b0;
		for (int i = dispatch_pkg::RP - 1; i >= 0; i--) begin
			if (!rd_used[i]) begin
				free_copy  = i[dispatch_pkg::RB-1:0];
				free_found = 1'b1;
			end
		end
	end

	always_comb begin
		if (rd_is_x0)
			rd_tag = '{idx: 5'd0, copy: '0};  // x0 stays on copy 0
		else
			rd_tag = '{idx: rd, copy: free_copy};
	end

	// copy to release once this instruction commits
	assign rd_prev_tag = '{idx: rd, copy: act[rd]};

	// x0 never allocates so it never runs out
	assign rd_runout = !rd_is_x0 && !free_found;

endmodule

//--- hdl/rename_state.sv
// rename tables: active copy per register and used copies, with allocate and release
module rename_state (
	input  logic                                                     CLK,
	input  logic                                                     rst_n,
	input  logic                                                     alloc,
	input  dispatch_pkg::reg_tag_t                                   alloc_tag,
	input  logic                                                     release_valid,
	input  dispatch_pkg::reg_tag_t                                   release_tag,
	output logic [dispatch_pkg::ARCH_REGS-1:0][dispatch_pkg::RB-1:0] act,
	output logic [dispatch_pkg::ARCH_REGS-1:0][dispatch_pkg::RP-1:0] used
);
	localparam logic [dispatch_pkg::RP-1:0] USED_RST = dispatch_pkg::RP'(1);  // copy 0 only

	// --------------------------------------------------
	// active copy table
	// --------------------------------------------------
	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			act <= '0;
		end else if (alloc) begin
			act[alloc_tag.idx] <= alloc_tag.copy;  // new writer becomes visible
		end
	end

	// --------------------------------------------------
	// used copy table
	// --------------------------------------------------
	// release and allocate hit different copies, both apply
	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			for (int r = 0; r < dispatch_pkg::ARCH_REGS; r++)
				used[r] <= USED_RST;
		end else begin
			if (release_valid)
				used[release_tag.idx][release_tag.copy] <= 1'b0;
			if (alloc)
				used[alloc_tag.idx][alloc_tag.copy] <= 1'b1;
		end
	end

	// allocation comes from rename's free search
	a_alloc_free: assert property (
		@(posedge CLK) disable iff (!rst_n)
		alloc |-> !used[alloc_tag.idx][alloc_tag.copy] && (alloc_tag.idx != 5'd0)
	) else $error("allocating a copy that is in use");

	// a committed previous copy has been superseded by a younger writer
	a_release_used: assert property (
		@(posedge CLK) disable iff (!rst_n)
		release_valid |-> used[release_tag.idx][release_tag.copy]
			&& (act[release_tag.idx] != release_tag.copy)
	) else $error("releasing a free or active copy");

endmodule

//--- hdl/sync_fifo.sv
// synchronous FIFO, circular buffer with wrap bits, typed payload
module sync_fifo #(
	parameter int  DEPTH = 4,
	parameter type T     = logic
) (
	input  logic CLK,
	input  logic rst_n,
	input  logic push,
	input  T     in,
	input  logic pop,
	output T     out,
	output logic full,
	output logic empty
);
	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	T mem [DEPTH];

	logic [AW-1:0] wr_idx;
	logic [AW-1:0] rd_idx;
	logic          wr_wrap;  // toggles each lap of the write pointer
	logic          rd_wrap;
	logic          do_push;
	logic          do_pop;

	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	assign empty = (wr_idx == rd_idx) && (wr_wrap == rd_wrap);
	assign full  = (wr_idx == rd_idx) && (wr_wrap != rd_wrap);
	assign out   = mem[rd_idx];  // head always visible

	always_ff @(posedge CLK) begin
		if (do_push)
			mem[wr_idx] <= in;
	end

	// pointers, depth need not be a power of two
	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			wr_idx  <= '0;
			rd_idx  <= '0;
			wr_wrap <= 1'b0;
			rd_wrap <= 1'b0;
		end else begin
			if (do_push) begin
				if (wr_idx == AW'(DEPTH - 1)) begin
					wr_idx  <= '0;
					wr_wrap <= !wr_wrap;
				end else
					wr_idx <= wr_idx + 1'b1;
			end
			if (do_pop) begin
				if (rd_idx == AW'(DEPTH - 1)) begin
					rd_idx  <= '0;
					rd_wrap <= !rd_wrap;
				end else
					rd_idx <= rd_idx + 1'b1;
			end
		end
	end

	a_no_overflow: assert property (@(posedge CLK) disable iff (!rst_n) push |-> !full)
		else $error("push into full FIFO");
	a_no_underflow: assert property (@(posedge CLK) disable iff (!rst_n) pop |-> !empty)
		else $error("pop from empty FIFO");

endmodule

//--- list.f
hdl/dispatch_pkg.sv
hdl/sync_fifo.sv
hdl/rename.sv
hdl/rename_state.sv
hdl/dispatch.sv
hdl/dispatch_top.sv
verif/tb_dispatch.sv

//--- verif/tb_dispatch.sv
// dispatch testbench: random instruction stream checked against a rename and queue model
module tb_dispatch;

	localparam int N_INSTR      = 2000;   // dispatched before the drain
	localparam int MAX_CYCLES   = 40000;
	localparam int DRAIN_CYCLES = 2000;

	logic                           CLK;
	logic                           rst_n;
	logic                           instr_push;
	dispatch_pkg::decode_info_t     instr_info;
	logic                           instr_full;
	logic [dispatch_pkg::UNITS-1:0] iss_pop;
	dispatch_pkg::issue_info_t      iss_data [dispatch_pkg::UNITS];
	logic [dispatch_pkg::UNITS-1:0] iss_empty;
	logic                           rob_pop;
	dispatch_pkg::rob_info_t        rob_data;
	logic                           rob_empty;

	// --------------------------------------------------
	// model state
	// --------------------------------------------------
	logic [31:0]                 rng;
	dispatch_pkg::decode_info_t  instr_q [$];                      // instruction FIFO contents
	dispatch_pkg::issue_info_t   exp_iss [dispatch_pkg::UNITS][$];
	dispatch_pkg::rob_info_t     exp_rob [$];
	logic [dispatch_pkg::RB-1:0] m_act  [dispatch_pkg::ARCH_REGS];
	logic [dispatch_pkg::RP-1:0] m_used [dispatch_pkg::ARCH_REGS];
	int                          cycle;
	int                          dispatched;
	int                          drain_start;
	int                          runout_stalls;
	int                          rob_stalls;
	int                          queue_stalls;

	dispatch_top uut (
		.CLK        (CLK),
		.rst_n      (rst_n),
		.instr_push (instr_push),
		.instr_info (instr_info),
		.instr_full (instr_full),
		.iss_pop    (iss_pop),
		.iss_data   (iss_data),
		.iss_empty  (iss_empty),
		.rob_pop    (rob_pop),
		.rob_data   (rob_data),
		.rob_empty  (rob_empty)
	);

	initial CLK = 1'b0;
	always #4 CLK = ~CLK;

	// xorshift32
	function automatic logic [31:0] next_random();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	// target queue of each opcode class
	function automatic dispatch_pkg::unit_e queue_of(dispatch_pkg::op_e op);
		if (op <= dispatch_pkg::op_addi)
			return dispatch_pkg::unit_alu;
		if (op <= dispatch_pkg::op_bne)
			return dispatch_pkg::unit_bru;
		if (op <= dispatch_pkg::op_fence)
			return dispatch_pkg::unit_lsu;
		if (op <= dispatch_pkg::op_csrrs)
			return dispatch_pkg::unit_csr;
		if (op <= dispatch_pkg::op_div)
			return dispatch_pkg::unit_mul;
		return dispatch_pkg::unit_none;
	endfunction

	function automatic dispatch_pkg::decode_info_t random_instr();
		dispatch_pkg::decode_info_t d;
		logic [31:0]                r;
		logic [4:0]                 opn;
		opn = 5'(next_random() % 21);
		r = next_random();
		d.op = dispatch_pkg::op_e'(opn);
		d.rs1 = r[4:0];
		d.rs2 = r[9:5];
		d.rd = r[10] ? {3'b000, r[12:11]} : r[17:13];  // x0..x3 often, to run out of copies
		d.pc[63:32] = next_random();
		d.pc[31:0] = next_random();
		d.imm[63:32] = next_random();
		d.imm[31:0] = next_random();
		return d;
	endfunction

	// --------------------------------------------------
	// checks
	// --------------------------------------------------
	task automatic abort_run();
		$display("Test failures found");
		$fatal(1);
	endtask

	task automatic check_issue(input string name, input dispatch_pkg::issue_info_t got,
		input dispatch_pkg::issue_info_t exp);
		if (got !== exp) begin
			$display("mismatch %s: got %h expected %h", name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_rob(input string name, input dispatch_pkg::rob_info_t got,
		input dispatch_pkg::rob_info_t exp);
		if (got !== exp) begin
			$display("mismatch %s: got %h expected %h", name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("mismatch %s: got %h expected %h", name, got, exp);
			abort_run();
		end
	endtask

	// one clock of stimulus, model update and checking
	task automatic step_cycle(input bit draining);
		dispatch_pkg::decode_info_t  hd;
		dispatch_pkg::unit_e         u;
		dispatch_pkg::issue_info_t   ii;
		dispatch_pkg::rob_info_t     ri;
		dispatch_pkg::rob_info_t     rel;
		logic [dispatch_pkg::RB-1:0] free_copy;
		logic [31:0]                 r;
		bit                          free_found;
		bit                          fire;
		bit                          do_release;
		bit                          pushing;
		int                          phase;
		int                          hold_q;
		bit                          rob_hold;

		@(posedge CLK);
		#1;
		cycle++;
		check_flag("instr_full", instr_full, instr_q.size() == dispatch_pkg::INSTR_DEPTH);
		check_flag("rob_empty", rob_empty, exp_rob.size() == 0);
		for (int q = 0; q < dispatch_pkg::UNITS; q++)
			check_flag($sformatf("iss_empty[%0d]", q), iss_empty[q], exp_iss[q].size() == 0);

		// dispatch decision on the state before this edge
		fire = 1'b0;
		if (instr_q.size() != 0) begin
			hd = instr_q[0];
			u = queue_of(hd.op);
			free_found = 1'b0;
			free_copy = '0;
			for (int c = 0; c < dispatch_pkg::RP; c++) begin
				if (!free_found && !m_used[hd.rd][c]) begin
					free_copy = c[dispatch_pkg::RB-1:0];
					free_found = 1'b1;
				end
			end
			ii.op = hd.op;
			ii.pc = hd.pc;
			ii.imm = hd.imm;
			ii.rs1 = '{idx: hd.rs1, copy: m_act[hd.rs1]};
			ii.rs2 = '{idx: hd.rs2, copy: m_act[hd.rs2]};
			ii.rd = (hd.rd == 5'd0) ? '{idx: 5'd0, copy: '0} : '{idx: hd.rd, copy: free_copy};
			ri = '0;
			ri.pc = hd.pc;
			ri.rd = ii.rd;
			ri.rd_prev = '{idx: hd.rd, copy: m_act[hd.rd]};
			ri.rd_valid = (hd.rd != 5'd0);
			case (hd.op)
				dispatch_pkg::op_beq, dispatch_pkg::op_bne:        ri.is_branch = 1'b1;
				dispatch_pkg::op_ld, dispatch_pkg::op_sd:          ri.is_ls = 1'b1;
				dispatch_pkg::op_csrrw, dispatch_pkg::op_csrrs:    ri.is_csr = 1'b1;
				dispatch_pkg::op_ecall, dispatch_pkg::op_ebreak,
				dispatch_pkg::op_mret:                             ri.is_priv = 1'b1;
				default: ;
			endcase
			if (exp_rob.size() == dispatch_pkg::ROB_DEPTH)
				rob_stalls++;
			else if (ri.rd_valid && !free_found)
				runout_stalls++;
			else if (u != dispatch_pkg::unit_none
					&& exp_iss[int'(u)].size() == dispatch_pkg::ISSUE_DEPTH)
				queue_stalls++;
			else
				fire = 1'b1;
		end

		// windows that hold one issue queue or the ROB unpopped
		phase = cycle % 500;
		hold_q = (phase >= 200 && phase < 260) ? (cycle / 500) % dispatch_pkg::UNITS : -1;
		rob_hold = (phase >= 400 && phase < 440);

		r = next_random();
		rob_pop = (exp_rob.size() != 0) && (draining || (!rob_hold && r[1:0] != 2'b00));
		for (int q = 0; q < dispatch_pkg::UNITS; q++)
			iss_pop[q] = (exp_iss[q].size() != 0) && (draining || (q != hold_q && r[q+2]));
		pushing = !draining && instr_q.size() < dispatch_pkg::INSTR_DEPTH && r[8];
		instr_push = pushing;
		if (pushing)
			instr_info = random_instr();

		do_release = 1'b0;
		if (rob_pop) begin
			check_rob("rob_data", rob_data, exp_rob[0]);
			rel = exp_rob.pop_front();
			do_release = rel.rd_valid;
		end
		for (int q = 0; q < dispatch_pkg::UNITS; q++) begin
			if (iss_pop[q]) begin
				check_issue($sformatf("iss_data[%0d]", q), iss_data[q], exp_iss[q][0]);
				void'(exp_iss[q].pop_front());
			end
		end

		// state after this edge
		if (do_release)
			m_used[rel.rd_prev.idx][rel.rd_prev.copy] = 1'b0;
		if (fire) begin
			void'(instr_q.pop_front());
			if (u != dispatch_pkg::unit_none)
				exp_iss[int'(u)].push_back(ii);
			exp_rob.push_back(ri);
			if (ri.rd_valid) begin
				m_used[hd.rd][ii.rd.copy] = 1'b1;
				m_act[hd.rd] = ii.rd.copy;
			end
			dispatched++;
		end
		if (pushing)
			instr_q.push_back(instr_info);
	endtask

	// --------------------------------------------------
	// main sequence
	// --------------------------------------------------
	initial begin
		rng = 32'ha8740cc3;
		rst_n = 1'b0;
		instr_push = 1'b0;
		instr_info = '0;
		iss_pop = '0;
		rob_pop = 1'b0;
		cycle = 0;
		dispatched = 0;
		runout_stalls = 0;
		rob_stalls = 0;
		queue_stalls = 0;
		for (int i = 0; i < dispatch_pkg::ARCH_REGS; i++) begin
			m_act[i] = '0;
			m_used[i] = dispatch_pkg::RP'(1);  // copy 0 live after reset
		end
		repeat (2) @(posedge CLK);
		#1;
		rst_n = 1'b1;

		while (dispatched < N_INSTR) begin
			if (cycle >= MAX_CYCLES) begin
				$display("timeout: only %0d instructions dispatched", dispatched);
				abort_run();
			end
			step_cycle(1'b0);
		end

		drain_start = cycle;
		while (instr_q.size() != 0 || exp_rob.size() != 0 || exp_iss[0].size() != 0
				|| exp_iss[1].size() != 0 || exp_iss[2].size() != 0
				|| exp_iss[3].size() != 0 || exp_iss[4].size() != 0) begin
			if (cycle - drain_start >= DRAIN_CYCLES) begin
				$display("timeout: queues did not drain");
				abort_run();
			end
			step_cycle(1'b1);
		end
		step_cycle(1'b1);  // all flags empty at the end

		if (runout_stalls == 0 || rob_stalls == 0 || queue_stalls == 0) begin
			$display("a stall case never occurred: runout %0d rob %0d queue %0d",
				runout_stalls, rob_stalls, queue_stalls);
			abort_run();
		end else begin
			$display("All tests passed!");
			$finish;
		end
	end

endmodule
